//--- filelist.f
+incdir+common
common/ppu_pkg.sv
common/vram_if.sv
hw/bg_pipe/bg_fetcher.sv
hw/bg_pipe/pixel_fifo.sv
hw/vram_bank.sv
hw/ppu_host_axil.sv
hw/ppu_bg_top.sv
tests/ppu_bg_checker.sv
tests/ppu_bg_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the background PPU testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module ppu_bg_tb -o ppu_bg_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build error"; exit 1; }

# An aborted simulation, for example on a failed assertion, is a failure too
./obj_dir/ppu_bg_sim > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log

grep -q "Some tests failed" sim.log && exit 1 || exit 0

//--- tests/ppu_bg_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_bg_tb;

  localparam int AW          = `PPU_AXI_AW;
  localparam int NUM_TESTS   = 6;
  localparam int LINE_PIXELS = 160;
  localparam int VRAM_BYTES  = 2**`PPU_VRAM_AW;
  // Pixel tests get 64 clocks per pixel, the VRAM fill gets 16 clocks per byte
  localparam int WATCHDOG_CYCLES = NUM_TESTS * LINE_PIXELS * 64 + VRAM_BYTES * 16;

  logic          clk;
  logic          reset;
  logic          dot_en;
  logic          line_start;
  logic [AW-1:0] s_axil_awaddr;
  logic          s_axil_awvalid;
  logic          s_axil_awready;
  logic [31:0]   s_axil_wdata;
  logic [3:0]    s_axil_wstrb;
  logic          s_axil_wvalid;
  logic          s_axil_wready;
  logic [1:0]    s_axil_bresp;
  logic          s_axil_bvalid;
  logic          s_axil_bready;
  logic [AW-1:0] s_axil_araddr;
  logic          s_axil_arvalid;
  logic          s_axil_arready;
  logic [31:0]   s_axil_rdata;
  logic [1:0]    s_axil_rresp;
  logic          s_axil_rvalid;
  logic          s_axil_rready;
  logic          pix_valid;
  logic [1:0]    pix_color;

  // Reference copy of VRAM and the four registers, built from the host writes
  logic [7:0]  vram_model [VRAM_BYTES];
  logic [7:0]  reg_model [4];
  logic [31:0] seed;
  logic [31:0] dot_seed;
  int          dot_mode;
  int          errors;
  int          test_start_errors;
  int          tests_run;
  int          tests_failed;

  ppu_bg_top dut0 (
    .clk            (clk),
    .reset          (reset),
    .dot_en         (dot_en),
    .line_start     (line_start),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .pix_valid      (pix_valid),
    .pix_color      (pix_color)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Colour of pixel k of the line, from the reference VRAM and registers
  function automatic logic [1:0] expected_color(input int k);
    logic [7:0]  lcdc;
    logic [7:0]  line_y;
    logic [4:0]  tile_col;
    logic [12:0] map_a;
    logic [12:0] data_a;
    logic [7:0]  idx;
    logic [7:0]  lo;
    logic [7:0]  hi;
    int          b;
    lcdc     = reg_model[ppu_pkg::REG_LCDC];
    line_y   = reg_model[ppu_pkg::REG_SCY] + reg_model[ppu_pkg::REG_LY];
    // Only the coarse scroll counts, and a map row of 32 tiles wraps
    tile_col = reg_model[ppu_pkg::REG_SCX][7:3] + 5'(k / 8);
    map_a    = 13'(int'(lcdc[6] ? `PPU_MAP1_BASE : `PPU_MAP0_BASE) +
                   32 * int'(line_y[7:3]) + int'(tile_col));
    idx      = vram_model[map_a];
    if (lcdc[4]) begin
      data_a = 13'(`PPU_TILE_UNSIGNED_BASE + 16 * int'(idx));
    end else begin
      data_a = 13'(`PPU_TILE_SIGNED_BASE + 16 * int'($signed(idx)));
    end
    data_a = data_a + 13'(2 * int'(line_y[2:0]));
    lo     = vram_model[data_a];
    hi     = vram_model[data_a + 13'd1];
    b      = 7 - (k % 8);
    return {hi[b], lo[b]};
  endfunction

  function automatic logic [AW-1:0] reg_addr(input int r);
    return AW'(`PPU_REG_SPACE + 4 * r);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic draw_byte(output logic [7:0] v);
    seed = lcg_step(seed);
    v    = seed[31:24];
  endtask

  task automatic draw_word(output logic [31:0] v);
    seed = lcg_step(seed);
    v    = seed;
  endtask

  task automatic axi_write(input logic [AW-1:0] addr, input logic [7:0] data);
    @(negedge clk);
    s_axil_awaddr  = addr;
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = {24'd0, data};
    s_axil_wstrb   = 4'h1;
    s_axil_wvalid  = 1'b1;
    while (!(s_axil_awready && s_axil_wready)) @(negedge clk);
    // The address and data handshake happens on the rising edge in between
    @(negedge clk);
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    while (!s_axil_bvalid) @(negedge clk);
    check_value("s_axil_bresp", 32'(s_axil_bresp), 32'h0);
    // Leave the response waiting for one cycle before taking it
    @(negedge clk);
    s_axil_bready = 1'b1;
    @(negedge clk);
    s_axil_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [AW-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    while (!s_axil_arready) @(negedge clk);
    @(negedge clk);
    s_axil_arvalid = 1'b0;
    while (!s_axil_rvalid) @(negedge clk);
    data = s_axil_rdata;
    check_value("s_axil_rresp", 32'(s_axil_rresp), 32'h0);
    // Leave the response waiting for one cycle before taking it
    @(negedge clk);
    s_axil_rready = 1'b1;
    @(negedge clk);
    s_axil_rready = 1'b0;
  endtask

  task automatic write_reg(input int r, input logic [7:0] v);
    axi_write(reg_addr(r), v);
    reg_model[r] = v;
  endtask

  task automatic set_regs(input logic [7:0] lcdc, input logic [7:0] scx,
                          input logic [7:0] scy, input logic [7:0] ly);
    write_reg(ppu_pkg::REG_LCDC, lcdc);
    write_reg(ppu_pkg::REG_SCX, scx);
    write_reg(ppu_pkg::REG_SCY, scy);
    write_reg(ppu_pkg::REG_LY, ly);
  endtask

  task automatic randomize_regs();
    logic [7:0] v;
    for (int r = 0; r < 4; r++) begin
      draw_byte(v);
      write_reg(r, v);
    end
  endtask

  task automatic read_vram_checked(input int addr);
    logic [31:0] rd;
    axi_read(AW'(addr), rd);
    check_value($sformatf("s_axil_rdata @%h", addr), rd, {24'd0, vram_model[addr]});
  endtask

  task automatic restart_line();
    @(negedge clk);
    line_start = 1'b1;
    @(negedge clk);
    line_start = 1'b0;
  endtask

  // Collects n pixels after a line start and compares them in screen order
  task automatic collect_line(input int n);
    int got;
    got = 0;
    while (got < n) begin
      @(negedge clk);
      if (pix_valid) begin
        check_value($sformatf("pix_color[%0d]", got), 32'(pix_color),
                    32'(expected_color(got)));
        got++;
      end
    end
  endtask

  task automatic begin_test();
    test_start_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_start_errors) begin
      tests_failed++;
    end
    $display("Test %0d %s %s (%0d mismatches)", tests_run, name,
             (errors == test_start_errors) ? "ok" : "FAIL", errors - test_start_errors);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Dot enable is off, on every cycle, or on with random gaps
  initial begin
    dot_en   = 1'b0;
    dot_seed = lcg_step(32'd3266);
    forever begin
      @(negedge clk);
      dot_seed = lcg_step(dot_seed);
      case (dot_mode)
        0:       dot_en = 1'b0;
        1:       dot_en = 1'b1;
        default: dot_en = (dot_seed[31:30] != 2'b00);
      endcase
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] w;
    logic [7:0]  b;
    seed           = 32'd3266;
    dot_mode       = 0;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    reset          = 1'b1;
    line_start     = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    begin_test();
    randomize_regs();
    for (int r = 0; r < 4; r++) begin
      axi_read(reg_addr(r), rd);
      check_value($sformatf("s_axil_rdata reg %0d", r), rd, {24'd0, reg_model[r]});
    end
    // Every VRAM byte gets a random value, so any tile fetch has a known answer
    for (int a = 0; a < VRAM_BYTES; a++) begin
      draw_byte(b);
      axi_write(AW'(a), b);
      vram_model[a] = b;
    end
    for (int i = 0; i < 64; i++) begin
      draw_word(w);
      read_vram_checked(int'(w[31:19]));
    end
    end_test("register and VRAM read-back");

    dot_mode = 1;
    begin_test();
    set_regs(8'h10, 8'h00, 8'h00, 8'h00);
    restart_line();
    collect_line(LINE_PIXELS);
    end_test("unsigned tiles, map 0");

    begin_test();
    draw_byte(b);
    set_regs(8'h40, 8'h00, 8'h00, b);
    restart_line();
    collect_line(LINE_PIXELS);
    end_test("signed tiles, map 1");

    begin_test();
    randomize_regs();
    restart_line();
    collect_line(LINE_PIXELS);
    end_test("random scroll and line");

    begin_test();
    randomize_regs();
    restart_line();
    dot_mode = 2;
    fork
      collect_line(LINE_PIXELS);
      begin
        for (int i = 0; i < 16; i++) begin
          draw_word(w);
          read_vram_checked(int'(w[31:19]));
        end
      end
    join
    dot_mode = 1;
    end_test("dot gaps with host reads");

    begin_test();
    randomize_regs();
    restart_line();
    collect_line(40);
    restart_line();
    collect_line(LINE_PIXELS);
    end_test("line start mid-line");

    $display("Tests run: %0d, tests with mismatches: %0d, total mismatches: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/ppu_bg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_bg_checker (
  input logic clk,
  input logic reset,
  input logic fetch_req,
  input logic host_req,
  input logic host_gnt,
  input logic host_we,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready
);

  // The fetcher asks at most one cycle in two, which leaves room for the host
  fetch_req_spaced: assert property (@(posedge clk) disable iff (reset)
    fetch_req |=> !fetch_req)
    else $error("Fetcher requested VRAM in two cycles in a row");

  // A host request losing to the fetcher is granted on the next cycle
  host_not_starved: assert property (@(posedge clk) disable iff (reset)
    (host_req && !host_gnt) |=> host_gnt)
    else $error("Host VRAM request not granted after losing one cycle");

  // Bank data follows one cycle after the grant and the AXI response one cycle later
  host_read_latency: assert property (@(posedge clk) disable iff (reset)
    (host_gnt && !host_we) |-> ##2 rvalid)
    else $error("AXI read data not valid two cycles after the VRAM grant");

  // AXI responses must wait for the master
  bvalid_held: assert property (@(posedge clk) disable iff (reset)
    (bvalid && !bready) |=> bvalid)
    else $error("Write response dropped before it was taken");

  rvalid_held: assert property (@(posedge clk) disable iff (reset)
    (rvalid && !rready) |=> rvalid)
    else $error("Read response dropped before it was taken");

endmodule

bind ppu_bg_top ppu_bg_checker u_checker (
  .clk       (clk),
  .reset     (reset),
  .fetch_req (fetch_bus.req),
  .host_req  (host_bus.req),
  .host_gnt  (host_bus.gnt),
  .host_we   (host_bus.we),
  .bvalid    (s_axil_bvalid),
  .bready    (s_axil_bready),
  .rvalid    (s_axil_rvalid),
  .rready    (s_axil_rready)
);

`default_nettype wire

//--- hw/ppu_bg_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_bg_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dot_en,
  input  logic                   line_start,
  input  logic [`PPU_AXI_AW-1:0] s_axil_awaddr,
  input  logic                   s_axil_awvalid,
  output logic                   s_axil_awready,
  input  logic [31:0]            s_axil_wdata,
  input  logic [3:0]             s_axil_wstrb,
  input  logic                   s_axil_wvalid,
  output logic                   s_axil_wready,
  output logic [1:0]             s_axil_bresp,
  output logic                   s_axil_bvalid,
  input  logic                   s_axil_bready,
  input  logic [`PPU_AXI_AW-1:0] s_axil_araddr,
  input  logic                   s_axil_arvalid,
  output logic                   s_axil_arready,
  output logic [31:0]            s_axil_rdata,
  output logic [1:0]             s_axil_rresp,
  output logic                   s_axil_rvalid,
  input  logic                   s_axil_rready,
  output logic                   pix_valid,
  output logic [1:0]             pix_color
);

  ppu_pkg::ppu_regs_t regs;
  ppu_pkg::pixel_t    push_data;
  logic               push;
  logic               fifo_empty;

  // One link per VRAM requester
  vram_if fetch_bus ();
  vram_if host_bus ();

  ppu_host_axil u_host (
    .clk            (clk),
    .reset          (reset),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .regs           (regs),
    .vram           (host_bus.requester)
  );

  vram_bank u_vram (
    .clk   (clk),
    .reset (reset),
    .fetch (fetch_bus.bank),
    .host  (host_bus.bank)
  );

  bg_fetcher u_fetcher (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .dot_en     (dot_en),
    .regs       (regs),
    .vram       (fetch_bus.requester),
    .push       (push),
    .push_data  (push_data),
    .empty      (fifo_empty)
  );

  pixel_fifo u_fifo (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .dot_en     (dot_en),
    .push       (push),
    .push_data  (push_data),
    .empty      (fifo_empty),
    .pix_valid  (pix_valid),
    .pix_color  (pix_color)
  );

endmodule

`default_nettype wire

//--- hw/ppu_host_axil.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module ppu_host_axil (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`PPU_AXI_AW-1:0] s_axil_awaddr,
  input  logic                   s_axil_awvalid,
  output logic                   s_axil_awready,
  input  logic [31:0]            s_axil_wdata,
  input  logic [3:0]             s_axil_wstrb,
  input  logic                   s_axil_wvalid,
  output logic                   s_axil_wready,
  output logic [1:0]             s_axil_bresp,
  output logic                   s_axil_bvalid,
  input  logic                   s_axil_bready,
  input  logic [`PPU_AXI_AW-1:0] s_axil_araddr,
  input  logic                   s_axil_arvalid,
  output logic                   s_axil_arready,
  output logic [31:0]            s_axil_rdata,
  output logic [1:0]             s_axil_rresp,
  output logic                   s_axil_rvalid,
  input  logic                   s_axil_rready,
  output ppu_pkg::ppu_regs_t     regs,
  vram_if.requester              vram
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACCEPT_W,
    ST_ACCEPT_R,
    ST_VRAM_WAIT,
    ST_VRAM_READ,
    ST_BRESP,
    ST_RRESP
  } host_state_t;

  host_state_t state;

  logic       aw_is_reg;
  logic       ar_is_reg;
  logic       w_fire;
  logic       ar_fire;
  logic [7:0] reg_rd_byte;

  assign aw_is_reg = (s_axil_awaddr >= `PPU_REG_SPACE);
  assign ar_is_reg = (s_axil_araddr >= `PPU_REG_SPACE);
  assign w_fire    = (state == ST_ACCEPT_W) && s_axil_awvalid && s_axil_wvalid;
  assign ar_fire   = (state == ST_ACCEPT_R) && s_axil_arvalid;

  assign s_axil_bresp = 2'b00;
  assign s_axil_rresp = 2'b00;

  always_comb begin
    case (ppu_pkg::host_reg_e'(s_axil_araddr[3:2]))
      ppu_pkg::REG_LCDC: reg_rd_byte = regs.lcdc;
      ppu_pkg::REG_SCX:  reg_rd_byte = regs.scx;
      ppu_pkg::REG_SCY:  reg_rd_byte = regs.scy;
      default:           reg_rd_byte = regs.ly;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state          <= ST_IDLE;
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      s_axil_arready <= 1'b0;
      s_axil_bvalid  <= 1'b0;
      s_axil_rvalid  <= 1'b0;
      vram.req       <= 1'b0;
      regs           <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Writes go first when both are pending
          if (s_axil_awvalid && s_axil_wvalid) begin
            s_axil_awready <= 1'b1;
            s_axil_wready  <= 1'b1;
            state          <= ST_ACCEPT_W;
          end else if (s_axil_arvalid) begin
            s_axil_arready <= 1'b1;
            state          <= ST_ACCEPT_R;
          end
        end
        ST_ACCEPT_W: begin
          if (w_fire) begin
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            if (aw_is_reg) begin
              if (s_axil_wstrb[0]) begin
                case (ppu_pkg::host_reg_e'(s_axil_awaddr[3:2]))
                  ppu_pkg::REG_LCDC: regs.lcdc <= s_axil_wdata[7:0];
                  ppu_pkg::REG_SCX:  regs.scx  <= s_axil_wdata[7:0];
                  ppu_pkg::REG_SCY:  regs.scy  <= s_axil_wdata[7:0];
                  default:           regs.ly   <= s_axil_wdata[7:0];
                endcase
              end
              s_axil_bvalid <= 1'b1;
              state         <= ST_BRESP;
            end else if (s_axil_wstrb[0]) begin
              vram.req <= 1'b1;
              state    <= ST_VRAM_WAIT;
            end else begin
              // Byte lane 0 disabled, nothing to store
              s_axil_bvalid <= 1'b1;
              state         <= ST_BRESP;
            end
          end
        end
        ST_ACCEPT_R: begin
          if (ar_fire) begin
            s_axil_arready <= 1'b0;
            if (ar_is_reg) begin
              s_axil_rvalid <= 1'b1;
              state         <= ST_RRESP;
            end else begin
              vram.req <= 1'b1;
              state    <= ST_VRAM_WAIT;
            end
          end
        end
        ST_VRAM_WAIT: begin
          if (vram.gnt) begin
            vram.req <= 1'b0;
            if (vram.we) begin
              s_axil_bvalid <= 1'b1;
              state         <= ST_BRESP;
            end else begin
              state <= ST_VRAM_READ;
            end
          end
        end
        ST_VRAM_READ: begin
          if (vram.rvalid) begin
            s_axil_rvalid <= 1'b1;
            state         <= ST_RRESP;
          end
        end
        ST_BRESP: begin
          if (s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
            state         <= ST_IDLE;
          end
        end
        ST_RRESP: begin
          if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
            state         <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request fields stay put from acceptance until the grant
  always_ff @(posedge clk) begin
    if (w_fire) begin
      vram.we    <= 1'b1;
      vram.addr  <= s_axil_awaddr[`PPU_VRAM_AW-1:0];
      vram.wdata <= s_axil_wdata[7:0];
    end else if (ar_fire) begin
      vram.we   <= 1'b0;
      vram.addr <= s_axil_araddr[`PPU_VRAM_AW-1:0];
    end
    if (ar_fire && ar_is_reg) begin
      s_axil_rdata <= {24'd0, reg_rd_byte};
    end else if (state == ST_VRAM_READ && vram.rvalid) begin
      s_axil_rdata <= {24'd0, vram.rdata};
    end
  end

endmodule

`default_nettype wire

//--- hw/vram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module vram_bank (
  input  logic clk,
  input  logic reset,
  vram_if.bank fetch,
  vram_if.bank host
);

  logic [7:0] mem [2**`PPU_VRAM_AW];

  logic [`PPU_VRAM_AW-1:0] sel_addr;
  logic [7:0]              sel_wdata;
  logic                    sel_we;
  logic [7:0]              rd_q;

  // Fetcher wins every conflict; it asks at most every other cycle
  assign fetch.gnt = fetch.req;
  assign host.gnt  = host.req && !fetch.req;

  // Single port, so one access per cycle on behalf of the winner
  always_comb begin
    if (fetch.req) begin
      sel_addr  = fetch.addr;
      sel_wdata = fetch.wdata;
      sel_we    = fetch.we;
    end else begin
      sel_addr  = host.addr;
      sel_wdata = host.wdata;
      sel_we    = host.we && host.req;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_we) begin
      mem[sel_addr] <= sel_wdata;
    end
    rd_q <= mem[sel_addr];
  end

  // Both sides see the same read register, only rvalid says whose data it is
  assign fetch.rdata = rd_q;
  assign host.rdata  = rd_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fetch.rvalid <= 1'b0;
      host.rvalid  <= 1'b0;
    end else begin
      fetch.rvalid <= fetch.gnt && !fetch.we;
      host.rvalid  <= host.gnt && !host.we;
    end
  end

endmodule

`default_nettype wire

//--- hw/bg_pipe/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module pixel_fifo (
  input  logic            clk,
  input  logic            reset,
  input  logic            line_start,
  input  logic            dot_en,
  input  logic            push,
  input  ppu_pkg::pixel_t push_data,
  output logic            empty,
  output logic            pix_valid,
  output logic [1:0]      pix_color
);

  localparam int PW = $clog2(`PPU_FIFO_DEPTH);

  ppu_pkg::pixel_t mem [`PPU_FIFO_DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign empty   = (count == '0);
  // Fetcher only pushes into an empty FIFO, so full is never expected
  assign do_push = push && (count != (PW+1)'(`PPU_FIFO_DEPTH));
  assign do_pop  = dot_en && !empty;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pix_valid <= 1'b0;
    end else if (line_start) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= do_pop && mem[rd_ptr].valid;
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
    if (do_pop) begin
      pix_color <= mem[rd_ptr].color;
    end
  end

endmodule

`default_nettype wire

//--- hw/bg_pipe/bg_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module bg_fetcher (
  input  logic                clk,
  input  logic                reset,
  input  logic                line_start,
  input  logic                dot_en,
  input  ppu_pkg::ppu_regs_t  regs,
  vram_if.requester           vram,
  output logic                push,
  output ppu_pkg::pixel_t     push_data,
  input  logic                empty
);

  typedef enum logic [2:0] {
    ST_GET_TILE,
    ST_GET_LOW,
    ST_GET_HIGH,
    ST_SLEEP,
    ST_PUSH
  } fetch_state_t;

  fetch_state_t state;

  // In the read states phase 0 issues the request and phase 1 waits for data.
  // In sleep the phase just counts the two dots
  logic phase;

  // Tile column within the visible line, bumped after every eight pixels
  logic [4:0] col;
  logic [2:0] push_idx;

  logic [7:0] tile_index;
  logic [7:0] tile_low;
  logic [7:0] tile_high;

  logic [7:0]              line_y;
  logic [4:0]              map_x;
  logic [`PPU_VRAM_AW-1:0] map_base;
  logic [`PPU_VRAM_AW-1:0] map_addr;
  logic [`PPU_VRAM_AW-1:0] row_addr;
  logic [2:0]              bit_sel;
  logic                    read_state;
  logic                    issue;

  // Background line inside the 256-line map, wraps on its own
  assign line_y   = regs.scy + regs.ly;
  assign map_x    = regs.scx[7:3] + col;
  assign map_base = regs.lcdc[6] ? `PPU_MAP1_BASE : `PPU_MAP0_BASE;
  // Each map row holds 32 tile indices
  assign map_addr = map_base + {3'b000, line_y[7:3], map_x};

  always_comb begin
    if (regs.lcdc[4]) begin
      row_addr = `PPU_TILE_UNSIGNED_BASE + {1'b0, tile_index, 4'b0000};
    end else begin
      // Index is a signed tile number around the upper base
      row_addr = `PPU_TILE_SIGNED_BASE + {tile_index[7], tile_index, 4'b0000};
    end
    row_addr = row_addr + {9'd0, line_y[2:0], 1'b0};
  end

  // Leftmost pixel lives in bit 7
  assign bit_sel = ~push_idx;

  assign read_state = (state == ST_GET_TILE) || (state == ST_GET_LOW) ||
                      (state == ST_GET_HIGH);
  assign issue      = read_state && !phase && dot_en;

  // The fetcher only ever reads
  assign vram.we    = 1'b0;
  assign vram.wdata = 8'h00;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= ST_GET_TILE;
      phase    <= 1'b0;
      col      <= 5'd0;
      push_idx <= 3'd0;
      vram.req <= 1'b0;
      push     <= 1'b0;
    end else if (line_start) begin
      state    <= ST_GET_TILE;
      phase    <= 1'b0;
      col      <= 5'd0;
      push_idx <= 3'd0;
      vram.req <= 1'b0;
      push     <= 1'b0;
    end else begin
      push <= 1'b0;
      // A granted access finishes even while dots are paused
      if (vram.gnt) begin
        vram.req <= 1'b0;
      end
      case (state)
        ST_GET_TILE, ST_GET_LOW, ST_GET_HIGH: begin
          if (issue) begin
            vram.req <= 1'b1;
            phase    <= 1'b1;
          end else if (phase && vram.rvalid) begin
            phase <= 1'b0;
            case (state)
              ST_GET_TILE: state <= ST_GET_LOW;
              ST_GET_LOW:  state <= ST_GET_HIGH;
              default:     state <= ST_SLEEP;
            endcase
          end
        end
        ST_SLEEP: begin
          if (dot_en) begin
            phase <= ~phase;
            if (phase) begin
              state <= ST_PUSH;
            end
          end
        end
        ST_PUSH: begin
          // Wait here until the FIFO has drained
          if (dot_en && empty) begin
            push     <= 1'b1;
            push_idx <= push_idx + 3'd1;
            if (push_idx == 3'd7) begin
              col   <= col + 5'd1;
              state <= ST_GET_TILE;
            end
          end
        end
        default: state <= ST_GET_TILE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      case (state)
        ST_GET_TILE: vram.addr <= map_addr;
        ST_GET_LOW:  vram.addr <= row_addr;
        default:     vram.addr <= row_addr + `PPU_VRAM_AW'(1);
      endcase
    end
    if (phase && vram.rvalid) begin
      case (state)
        ST_GET_TILE: tile_index <= vram.rdata;
        ST_GET_LOW:  tile_low   <= vram.rdata;
        ST_GET_HIGH: tile_high  <= vram.rdata;
        default: ;
      endcase
    end
    if (state == ST_PUSH && dot_en && empty) begin
      push_data.color <= {tile_high[bit_sel], tile_low[bit_sel]};
      push_data.valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- common/vram_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

// One requester's link to the shared VRAM bank
interface vram_if;
  logic                    req;
  logic                    we;
  logic [`PPU_VRAM_AW-1:0] addr;
  logic [7:0]              wdata;
  logic                    gnt;
  logic                    rvalid;
  logic [7:0]              rdata;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport bank (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata
  );
endinterface

`default_nettype wire

//--- common/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

  // One background pixel as it travels from the fetcher to the pixel FIFO
  typedef struct packed {
    logic [1:0] color;
    logic       valid;
  } pixel_t;

  // Host-visible control registers, all one byte wide
  typedef struct packed {
    // Bit 6 picks the tile map, bit 4 picks unsigned tile data
    logic [7:0] lcdc;
    logic [7:0] scx;
    logic [7:0] scy;
    // Line number, written by the host since there is no line counter here
    logic [7:0] ly;
  } ppu_regs_t;

  // Word offsets of the registers above the register space base
  typedef enum logic [1:0] {
    REG_LCDC = 2'd0,
    REG_SCX  = 2'd1,
    REG_SCY  = 2'd2,
    REG_LY   = 2'd3
  } host_reg_e;

endpackage

`default_nettype wire

//--- common/ppu_cfg.svh
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// VRAM is 8 KiB of bytes
`define PPU_VRAM_AW 13

// Pixel FIFO depth, kept a power of two so the pointers wrap on their own
`define PPU_FIFO_DEPTH 8

// Tile map bases, chosen by LCDC bit 6
`define PPU_MAP0_BASE 13'h1800
`define PPU_MAP1_BASE 13'h1C00

// Tile data bases, chosen by LCDC bit 4
`define PPU_TILE_SIGNED_BASE 13'h1000
`define PPU_TILE_UNSIGNED_BASE 13'h0000

// Host address map: VRAM sits below the register space
`define PPU_AXI_AW 16
`define PPU_REG_SPACE 16'h2000

`endif
